// ==== list.f ====
+incdir+verif
source/fib_pkg.sv
source/prefix_hash.sv
source/interest_rx.sv
source/fib_store.sv
source/lpm_search.sv
source/lpm_tx.sv
source/fib_top.sv
verif/tb_fib_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FIB testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_fib_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_fib_top 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== source/fib_pkg.sv ====
/*
 * Shared FIB definitions
 *   Packet format widths and table geometry
 *   Vector typedefs for bytes, prefixes, hashes and lengths
 *   Packed records for metadata, interests and lookup results
 */
`default_nettype none

package fib_pkg;

    // Packet format and table geometry
    localparam int PREFIX_BYTES = 8;
    localparam int HASH_W       = 10;
    localparam int LEN_LEVELS   = 64;

    // One byte on the SPI link
    typedef logic [7:0] spi_byte_t;

    // Name prefix, sent most significant byte first
    typedef logic [PREFIX_BYTES*8-1:0] prefix_t;

    // Table column and table row
    typedef logic [HASH_W-1:0] hash_t;
    typedef logic [$clog2(LEN_LEVELS)-1:0] prefix_len_t;

    // Metadata byte as it arrives on the link
    typedef struct packed {
        logic        spare;
        logic        is_interest;
        prefix_len_t len;
    } meta_t;

    // Interest record between FIB and PIT
    typedef struct packed {
        meta_t   meta;
        prefix_t prefix;
    } interest_t;

    // Search result handed to the output side
    typedef struct packed {
        meta_t   meta;
        prefix_t total_prefix;
        prefix_t longest_prefix;
    } lpm_result_t;

endpackage

`default_nettype wire

// ==== source/fib_store.sv ====
/*
 * FIB valid-bit table
 *   64 rows by length, 1024 columns by prefix hash
 *   Learning write path with its own hash unit
 *   Combinational read port for the search
 */
`timescale 1ns/1ps
`default_nettype none

module fib_store
    import fib_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        learn_valid,
    input  interest_t   learn,
    input  prefix_len_t rd_len,
    input  hash_t       rd_hash,
    output logic        rd_hit
);

    // One bit per row and column
    logic [LEN_LEVELS-1:0][2**HASH_W-1:0] valid_q;

    hash_t       learn_hash;
    prefix_len_t wr_len_q;
    logic        wr_en_q;

    // Column of the learned prefix, ready one cycle after learn_valid
    prefix_hash learn_hash_inst (
        .clk    (clk),
        .rst    (rst),
        .prefix (learn.prefix),
        .hash   (learn_hash)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            wr_en_q  <= 1'b0;
            wr_len_q <= '0;
        end else begin
            // Row and enable wait one cycle for the hash
            wr_en_q  <= learn_valid;
            wr_len_q <= learn.meta.len;
            if (wr_en_q) begin
                valid_q[wr_len_q][learn_hash] <= 1'b1;
            end
        end
    end

    // Lookup for the current search level
    assign rd_hit = valid_q[rd_len][rd_hash];

endmodule

`default_nettype wire

// ==== source/fib_top.sv ====
/*
 * FIB top level
 *   Input side, valid-bit table, longest-prefix search
 *   and output side wired together
 */
`timescale 1ns/1ps
`default_nettype none

module fib_top
    import fib_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_valid,
    input  spi_byte_t data_spi_to_fib,
    input  logic      fib_out_bit,
    input  interest_t pit_in,
    output logic      prefix_ready,
    output interest_t pit_out,
    output logic      spi_tx_flag,
    output spi_byte_t data_fib_to_spi
);

    // Learning path
    logic      learn_valid;
    interest_t learn;

    // Table read port
    prefix_len_t rd_len;
    hash_t       rd_hash;
    logic        rd_hit;

    // Search to output side
    logic        result_valid;
    lpm_result_t result;
    logic        tx_busy;

    interest_rx interest_rx_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_valid        (rx_valid),
        .data_spi_to_fib (data_spi_to_fib),
        .prefix_ready    (prefix_ready),
        .pit_out         (pit_out),
        .learn_valid     (learn_valid),
        .learn           (learn)
    );

    fib_store fib_store_inst (
        .clk         (clk),
        .rst         (rst),
        .learn_valid (learn_valid),
        .learn       (learn),
        .rd_len      (rd_len),
        .rd_hash     (rd_hash),
        .rd_hit      (rd_hit)
    );

    lpm_search lpm_search_inst (
        .clk          (clk),
        .rst          (rst),
        .fib_out_bit  (fib_out_bit),
        .pit_in       (pit_in),
        .rd_hit       (rd_hit),
        .tx_busy      (tx_busy),
        .rd_len       (rd_len),
        .rd_hash      (rd_hash),
        .result_valid (result_valid),
        .result       (result)
    );

    lpm_tx lpm_tx_inst (
        .clk             (clk),
        .rst             (rst),
        .result_valid    (result_valid),
        .result          (result),
        .tx_busy         (tx_busy),
        .spi_tx_flag     (spi_tx_flag),
        .data_fib_to_spi (data_fib_to_spi)
    );

endmodule

`default_nettype wire

// ==== source/interest_rx.sv ====
/*
 * Input side of the FIB
 *   Parses one metadata byte and eight prefix bytes from SPI
 *   Pulses interest packets to the PIT hash table and the learning path
 */
`timescale 1ns/1ps
`default_nettype none

module interest_rx
    import fib_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_valid,
    input  spi_byte_t data_spi_to_fib,
    output logic      prefix_ready,
    output interest_t pit_out,
    output logic      learn_valid,
    output interest_t learn
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_META,
        RX_PREFIX
    } rx_state_t;

    rx_state_t state_q;
    logic [2:0] byte_cnt_q;
    logic       ready_q;
    meta_t      meta_q;
    prefix_t    prefix_q;
    prefix_t    prefix_next;
    interest_t  packet_q;
    logic       last_byte;

    // Prefix with the current byte shifted in at the bottom
    assign prefix_next = {prefix_q[55:0], data_spi_to_fib};
    assign last_byte   = (state_q == RX_PREFIX) && (byte_cnt_q == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= RX_IDLE;
            byte_cnt_q <= '0;
            ready_q    <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    // rx_valid only counts here
                    if (rx_valid) begin
                        state_q <= RX_META;
                    end
                end
                RX_META: begin
                    byte_cnt_q <= 3'(PREFIX_BYTES - 1);
                    state_q    <= RX_PREFIX;
                end
                RX_PREFIX: begin
                    byte_cnt_q <= byte_cnt_q - 3'd1;
                    if (byte_cnt_q == '0) begin
                        // Data packets are consumed silently
                        ready_q <= meta_q.is_interest;
                        state_q <= RX_IDLE;
                    end
                end
                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RX_META) begin
            meta_q <= meta_t'(data_spi_to_fib);
        end
        if (state_q == RX_PREFIX) begin
            prefix_q <= prefix_next;
        end
        // Record captured with the last byte, same edge as the pulse
        if (last_byte && meta_q.is_interest) begin
            packet_q <= '{meta: meta_q, prefix: prefix_next};
        end
    end

    // PIT and learning path see the same record
    assign prefix_ready = ready_q;
    assign learn_valid  = ready_q;
    assign pit_out      = packet_q;
    assign learn        = packet_q;

    // A full packet lies between two pulses
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst) prefix_ready |=> !prefix_ready
    );

endmodule

`default_nettype wire

// ==== source/lpm_search.sv ====
/*
 * Longest-prefix search
 *   Takes an interest from the PIT and walks the length rows downward
 *   Two cycles per level, hash then check
 *   Holds the result until the output side is free
 */
`timescale 1ns/1ps
`default_nettype none

module lpm_search
    import fib_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fib_out_bit,
    input  interest_t   pit_in,
    input  logic        rd_hit,
    input  logic        tx_busy,
    output prefix_len_t rd_len,
    output hash_t       rd_hash,
    output logic        result_valid,
    output lpm_result_t result
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HASH,
        S_CHECK,
        S_HOLD
    } search_state_t;

    search_state_t state_q;
    prefix_len_t   len_q;
    prefix_t       work_q;
    prefix_t       total_q;
    meta_t         meta_q;
    hash_t         work_hash;
    logic          done;

    // Hash of the working prefix, ready in the check cycle
    prefix_hash search_hash_inst (
        .clk    (clk),
        .rst    (rst),
        .prefix (work_q),
        .hash   (work_hash)
    );

    assign rd_len  = len_q;
    assign rd_hash = work_hash;

    // Hit, or nothing shorter left to try
    assign done = rd_hit || (len_q == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            len_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fib_out_bit) begin
                        len_q   <= pit_in.meta.len;
                        state_q <= S_HASH;
                    end
                end
                S_HASH: begin
                    state_q <= S_CHECK;
                end
                S_CHECK: begin
                    if (done) begin
                        state_q <= S_HOLD;
                    end else begin
                        len_q   <= len_q - prefix_len_t'(1);
                        state_q <= S_HASH;
                    end
                end
                S_HOLD: begin
                    // Released once the output side takes it
                    if (!tx_busy) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && fib_out_bit) begin
            work_q  <= pit_in.prefix;
            total_q <= pit_in.prefix;
            meta_q  <= pit_in.meta;
        end
        // Drop the bit numbered by the current length on a miss
        if (state_q == S_CHECK && !done) begin
            work_q[len_q] <= 1'b0;
        end
    end

    assign result_valid = (state_q == S_HOLD);
    assign result       = '{meta: meta_q, total_prefix: total_q, longest_prefix: work_q};

    // Search stops at length zero, never wraps around to the top row
    a_len_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        (state_q != S_IDLE && len_q == '0) |=> (len_q != '1)
    );

endmodule

`default_nettype wire

// ==== source/lpm_tx.sv ====
/*
 * Output side of the FIB
 *   Accepts a search result and sends a flag cycle
 *   followed by metadata, total prefix and longest prefix, MSB first
 */
`timescale 1ns/1ps
`default_nettype none

module lpm_tx
    import fib_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        result_valid,
    input  lpm_result_t result,
    output logic        tx_busy,
    output logic        spi_tx_flag,
    output spi_byte_t   data_fib_to_spi
);

    typedef enum logic [2:0] {
        T_IDLE,
        T_FLAG,
        T_META,
        T_TOTAL,
        T_LONGEST
    } tx_state_t;

    tx_state_t  state_q;
    logic [2:0] byte_cnt_q;
    meta_t      meta_q;
    prefix_t    total_sr;
    prefix_t    longest_sr;
    logic       accept;

    assign tx_busy = (state_q != T_IDLE);
    assign accept  = result_valid && !tx_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= T_IDLE;
            byte_cnt_q <= '0;
        end else begin
            case (state_q)
                T_IDLE: begin
                    if (accept) begin
                        state_q <= T_FLAG;
                    end
                end
                T_FLAG: begin
                    state_q <= T_META;
                end
                T_META: begin
                    byte_cnt_q <= 3'(PREFIX_BYTES - 1);
                    state_q    <= T_TOTAL;
                end
                T_TOTAL: begin
                    byte_cnt_q <= byte_cnt_q - 3'd1;
                    if (byte_cnt_q == '0) begin
                        // Counter wraps to 7 for the next prefix
                        state_q <= T_LONGEST;
                    end
                end
                T_LONGEST: begin
                    byte_cnt_q <= byte_cnt_q - 3'd1;
                    if (byte_cnt_q == '0) begin
                        state_q <= T_IDLE;
                    end
                end
                default: begin
                    state_q <= T_IDLE;
                end
            endcase
        end
    end

    // Shift registers, top byte is the one on the link
    always_ff @(posedge clk) begin
        if (accept) begin
            meta_q     <= result.meta;
            total_sr   <= result.total_prefix;
            longest_sr <= result.longest_prefix;
        end
        if (state_q == T_TOTAL) begin
            total_sr <= total_sr << 8;
        end
        if (state_q == T_LONGEST) begin
            longest_sr <= longest_sr << 8;
        end
    end

    always_comb begin
        case (state_q)
            T_META:    data_fib_to_spi = spi_byte_t'(meta_q);
            T_TOTAL:   data_fib_to_spi = total_sr[63:56];
            T_LONGEST: data_fib_to_spi = longest_sr[63:56];
            default:   data_fib_to_spi = '0;
        endcase
    end

    assign spi_tx_flag = (state_q == T_FLAG);

    // Flag only follows a handshake with the search
    a_flag_after_accept: assert property (
        @(posedge clk) disable iff (rst) spi_tx_flag |-> $past(accept)
    );

endmodule

`default_nettype wire

// ==== source/prefix_hash.sv ====
/*
 * Prefix hash
 *   XOR fold of a 64-bit prefix into a table column
 *   One register stage, result valid one cycle after the input
 */
`timescale 1ns/1ps
`default_nettype none

module prefix_hash
    import fib_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  prefix_t prefix,
    output hash_t   hash
);

    // Number of full slices that fit in a prefix
    localparam int SLICES = $bits(prefix_t) / HASH_W;

    hash_t fold;

    always_comb begin
        // Leftover top bits, zero padded at the top
        fold = hash_t'(prefix[$bits(prefix_t)-1:SLICES*HASH_W]);
        for (int i = 0; i < SLICES; i++) begin
            fold = fold ^ prefix[i*HASH_W +: HASH_W];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

`default_nettype wire

// ==== verif/fib_model.svh ====
/*
 * Reference model for the FIB testbench
 *   Column hash, learned-bit table, longest-prefix search
 */
`ifndef FIB_MODEL_SVH
`define FIB_MODEL_SVH

// Learned bits, row by length and column by hash
bit model_table [LEN_LEVELS][2**HASH_W];

// Six 10-bit slices and the top four bits, XORed together
function automatic hash_t fold_hash(input prefix_t p);
    hash_t h;
    h = {6'b0, p[63:60]};
    for (int i = 0; i < 6; i++) begin
        h = h ^ p[i*10 +: 10];
    end
    return h;
endfunction

function automatic void learn_entry(input meta_t meta, input prefix_t prefix);
    model_table[meta.len][fold_hash(prefix)] = 1'b1;
endfunction

// Walk down from the request length, dropping bit len on every miss
function automatic lpm_result_t expected_result(input interest_t req);
    lpm_result_t res;
    prefix_t     work;
    int          len;
    work = req.prefix;
    len  = req.meta.len;
    while (!model_table[len][fold_hash(work)] && len > 0) begin
        work[len] = 1'b0;
        len--;
    end
    res.meta           = req.meta;
    res.total_prefix   = req.prefix;
    res.longest_prefix = work;
    return res;
endfunction

`endif

// ==== verif/tb_fib_top.sv ====
/*
 * Testbench for the FIB top level
 *   Clock, reset, SPI packet and lookup stimulus
 *   Comparing process for prefix_ready and the SPI output bytes
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fib_top
    import fib_pkg::*;
();

    // Longest wait for any pulse, in cycles
    localparam int WAIT_LIMIT = 400;

    logic      clk;
    logic      rst;
    logic      rx_valid;
    spi_byte_t data_spi_to_fib;
    logic      fib_out_bit;
    interest_t pit_in;
    logic      prefix_ready;
    interest_t pit_out;
    logic      spi_tx_flag;
    spi_byte_t data_fib_to_spi;

    int cycle_cnt = 0;

    // Expected PIT records with the cycle of their pulse
    interest_t   ready_q[$];
    int          ready_cycle_q[$];
    // Expected search results in send order
    lpm_result_t result_q[$];
    interest_t   learned[$];

    // Byte position after the flag, 0 when no transfer runs
    int          tx_index = 0;
    lpm_result_t tx_expected;

    `include "fib_model.svh"

    fib_top fib_top_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_valid        (rx_valid),
        .data_spi_to_fib (data_spi_to_fib),
        .fib_out_bit     (fib_out_bit),
        .pit_in          (pit_in),
        .prefix_ready    (prefix_ready),
        .pit_out         (pit_out),
        .spi_tx_flag     (spi_tx_flag),
        .data_fib_to_spi (data_fib_to_spi)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input logic [135:0] actual, input logic [135:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string reason);
        $display("Timeout at %0t ns: %s", $time, reason);
        $display("Test FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // Inputs change a little after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic meta_t make_meta(input logic is_interest, input int len);
        meta_t m;
        m.spare       = 1'b0;
        m.is_interest = is_interest;
        m.len         = prefix_len_t'(len);
        return m;
    endfunction

    // Ones in bits len down to 0
    function automatic prefix_t len_mask(input int len);
        return ~64'h0 >> (63 - len);
    endfunction

    // Bytes 1 to 17 after the flag, MSB first
    function automatic spi_byte_t result_byte(input lpm_result_t res, input int i);
        if (i == 1) begin
            return spi_byte_t'(res.meta);
        end else if (i <= 9) begin
            return res.total_prefix[(9-i)*8 +: 8];
        end
        return res.longest_prefix[(17-i)*8 +: 8];
    endfunction

    // rx_valid strobe, metadata, then eight prefix bytes
    task automatic send_packet(input meta_t meta, input prefix_t prefix);
        interest_t rec;
        rec.meta   = meta;
        rec.prefix = prefix;
        step();
        rx_valid = 1'b1;
        if (meta.is_interest) begin
            ready_q.push_back(rec);
            ready_cycle_q.push_back(cycle_cnt + 10);
            learn_entry(meta, prefix);
        end
        step();
        rx_valid        = 1'b0;
        data_spi_to_fib = spi_byte_t'(meta);
        for (int i = PREFIX_BYTES - 1; i >= 0; i--) begin
            step();
            data_spi_to_fib = prefix[i*8 +: 8];
        end
        step();
        data_spi_to_fib = '0;
        // Room for the pulse and the table write
        repeat (4) step();
    endtask

    // Returns once the result is taken, so the search is idle again
    task automatic lookup(input meta_t meta, input prefix_t prefix);
        interest_t req;
        int        waited;
        req.meta   = meta;
        req.prefix = prefix;
        result_q.push_back(expected_result(req));
        step();
        fib_out_bit = 1'b1;
        pit_in      = req;
        step();
        fib_out_bit = 1'b0;
        waited      = 0;
        @(negedge clk);
        while (!spi_tx_flag) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("no spi_tx_flag after a lookup");
            end
            @(negedge clk);
        end
    endtask

    // Comparing process, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (prefix_ready) begin
                check_value(ready_q.size() > 0, 1'b1, "prefix_ready without an interest");
                check_value(cycle_cnt, ready_cycle_q.pop_front(), "prefix_ready cycle");
                check_value(pit_out, ready_q.pop_front(), "pit_out record");
            end
            if (tx_index > 0) begin
                check_value(spi_tx_flag, 1'b0, "spi_tx_flag inside a transfer");
                check_value(data_fib_to_spi, result_byte(tx_expected, tx_index),
                            $sformatf("byte %0d after spi_tx_flag", tx_index));
                tx_index = (tx_index == 17) ? 0 : tx_index + 1;
            end else if (spi_tx_flag) begin
                check_value(result_q.size() > 0, 1'b1, "spi_tx_flag without a lookup");
                tx_expected = result_q.pop_front();
                tx_index    = 1;
            end
        end
    end

    initial begin : stimulus
        interest_t entry;
        prefix_t   prefix;
        int        pick;
        int        len;
        int        waited;
        rst             = 1'b1;
        rx_valid        = 1'b0;
        data_spi_to_fib = '0;
        fib_out_bit     = 1'b0;
        pit_in          = '0;
        void'($urandom(32'hcb7d2470));
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet outputs with no input
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value(prefix_ready, 1'b0, "prefix_ready while idle");
            check_value(spi_tx_flag, 1'b0, "spi_tx_flag while idle");
        end

        // Empty table, bits 1 up to the length cleared
        lookup(make_meta(1'b1, 40), 64'hfedc_ba98_7654_3210);
        lookup(make_meta(1'b1, 0), 64'h0f0f_0f0f_0f0f_0f0f);

        // Learned interest, then longer lookups that fall back to it
        send_packet(make_meta(1'b1, 20), 64'h0000_0000_0012_3456);
        lookup(make_meta(1'b1, 20), 64'h0000_0000_0012_3456);
        lookup(make_meta(1'b1, 25), 64'h0000_0000_0332_3456);
        lookup(make_meta(1'b1, 63), 64'hdead_beef_0012_3456);

        // Data packet consumed but never learned
        send_packet(make_meta(1'b0, 33), 64'h0000_0001_cafe_f00d);
        lookup(make_meta(1'b1, 33), 64'h0000_0001_cafe_f00d);

        // Random mix, back-to-back lookups overlap the SPI output
        for (int n = 0; n < 60; n++) begin
            pick   = $urandom_range(0, 9);
            len    = $urandom_range(0, 63);
            prefix = {$urandom, $urandom} & len_mask(len);
            if (pick < 3) begin
                send_packet(make_meta(1'b1, len), prefix);
                entry.meta   = make_meta(1'b1, len);
                entry.prefix = prefix;
                learned.push_back(entry);
            end else if (pick == 3) begin
                send_packet(make_meta(1'b0, len), prefix);
            end else if (pick < 8 && learned.size() > 0) begin
                entry  = learned[$urandom_range(0, learned.size() - 1)];
                len    = $urandom_range(entry.meta.len, 63);
                prefix = entry.prefix | ({$urandom, $urandom} & len_mask(len) &
                                         ~len_mask(entry.meta.len));
                lookup(make_meta(1'b1, len), prefix);
            end else begin
                lookup(make_meta(1'b1, len), {$urandom, $urandom});
            end
        end

        // Drain what is still in flight
        waited = 0;
        while (result_q.size() != 0 || tx_index != 0 || ready_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("outputs still pending at the end of the run");
            end
            @(negedge clk);
        end
        repeat (5) step();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
